// ==== Makefile ====
VERILATOR ?= verilator
TOP       := uart_tb
FILELIST  := uart_periph.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) design/uart_settings.svh
PASS_MSG  := NO ERRORS

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== design/uart_baud_gen.sv ====
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_baud_gen (
    input  logic clk,
    input  logic rst_n,
    output logic baud_tick
);

    localparam int CNT_W = ($clog2(`UART_PRESCALE) < 1) ? 1 : $clog2(`UART_PRESCALE);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_PRESCALE - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt       <= '0;
            baud_tick <= 1'b0;
        end else if (cnt == CNT_LAST) begin
            cnt       <= '0;
            baud_tick <= 1'b1;  // One clk wide
        end else begin
            cnt       <= cnt + 1'b1;
            baud_tick <= 1'b0;
        end
    end

endmodule

// ==== design/uart_link_if.sv ====
`timescale 1ns/1ps

interface uart_link_if import uart_pkg::*; ();

    // Transmit side
    uart_byte_t tx_data;    // Transmit buffer contents
    logic       tx_load;    // Buffer holds an unsent byte
    logic       tx_taken;   // Byte copied into the shift register

    // Receive side
    uart_byte_t rx_data;    // Valid with rx_valid
    logic       rx_valid;   // Good stop bit
    logic       frame_err;  // Bad stop bit

    modport regs (
        output tx_data, tx_load,
        input  tx_taken,
        input  rx_data, rx_valid, frame_err
    );

    modport tx (
        input  tx_data, tx_load,
        output tx_taken
    );

    modport rx (
        output rx_data, rx_valid, frame_err
    );

endinterface

// ==== design/uart_pkg.sv ====
package uart_pkg;

    typedef logic [7:0] uart_byte_t;

    // Control/status register, bit 0 at the bottom
    typedef struct packed {
        logic [3:0] rsvd;       // Read as zero
        logic       overrun;    // Sticky, write 1 to clear
        logic       frame_err;  // Sticky, write 1 to clear
        logic       tx_empty;
        logic       rx_full;
    } uart_status_t;

    typedef enum logic [2:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop,
        rx_st_wait_high
    } rx_state_t;

    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } tx_state_t;

endpackage

// ==== design/uart_regs.sv ====
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_regs import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  address,
    input  uart_byte_t  din,
    input  logic        w_en,
    input  logic        r_en,
    output uart_byte_t  dout,
    uart_link_if.regs   link
);

    localparam logic [7:0] CTRL_ADDR = `UART_BASE_ADDR;
    localparam logic [7:0] BUF_ADDR  = CTRL_ADDR + 8'd1;

    uart_status_t status;
    uart_status_t clr_mask;
    uart_byte_t   tx_buf;
    uart_byte_t   rx_buf;
    logic         ctrl_sel;
    logic         buf_sel;
    logic         rd_buf;
    logic         store_rx;

    assign ctrl_sel = (address == CTRL_ADDR);
    assign buf_sel  = (address == BUF_ADDR);
    assign rd_buf   = r_en && buf_sel;
    assign clr_mask = uart_status_t'(din);

    // Buffer is free if empty or being read this cycle
    assign store_rx = link.rx_valid && (!status.rx_full || rd_buf);

    // ********************
    // Data buffers

    always_ff @(posedge clk) begin
        if (w_en && buf_sel) tx_buf <= din;
        if (store_rx)        rx_buf <= link.rx_data;
    end

    // ********************
    // Status and read port

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status          <= '0;
            status.tx_empty <= 1'b1;
            dout            <= '0;
        end else begin
            if (w_en && buf_sel) begin
                status.tx_empty <= 1'b0;    // New byte overwrites any unsent one
            end else if (link.tx_taken) begin
                status.tx_empty <= 1'b1;
            end

            if (store_rx) begin
                status.rx_full <= 1'b1;
            end else if (rd_buf) begin
                status.rx_full <= 1'b0;
            end

            // Set wins over write-1-to-clear
            if (link.rx_valid && !store_rx) begin
                status.overrun <= 1'b1;
            end else if (w_en && ctrl_sel && clr_mask.overrun) begin
                status.overrun <= 1'b0;
            end

            if (link.frame_err) begin
                status.frame_err <= 1'b1;
            end else if (w_en && ctrl_sel && clr_mask.frame_err) begin
                status.frame_err <= 1'b0;
            end

            if (r_en) begin
                if (ctrl_sel)     dout <= status;
                else if (buf_sel) dout <= rx_buf;
                else              dout <= '0;   // Unmapped
            end
        end
    end

    assign link.tx_data = tx_buf;
    assign link.tx_load = ~status.tx_empty;

endmodule

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        baud_tick,
    input  logic        rx,
    uart_link_if.rx     link
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] TICK_HALF = TICK_W'(`UART_OVERSAMPLE / 2 - 1);

    logic [1:0]        sync_q;
    logic              rx_s;
    rx_state_t         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    uart_byte_t        shift_q;
    logic              rx_valid_q;
    logic              frame_err_q;

    // ********************
    // Input synchronizer

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= 2'b11;    // Line idles high
        end else begin
            sync_q <= {sync_q[0], rx};
        end
    end

    assign rx_s = sync_q[1];

    // ********************
    // Receive FSM

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= rx_st_idle;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            rx_valid_q  <= 1'b0;
            frame_err_q <= 1'b0;
            if (baud_tick) begin
                case (state)
                    rx_st_idle: begin
                        tick_cnt <= '0;
                        if (!rx_s) state <= rx_st_start;
                    end
                    rx_st_start: begin
                        if (tick_cnt == TICK_HALF) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_s ? rx_st_idle : rx_st_data;  // High means glitch
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    rx_st_data: begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            bit_cnt  <= bit_cnt + 1'b1;
                            if (bit_cnt == 3'd7) state <= rx_st_stop;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    rx_st_stop: begin
                        if (tick_cnt == TICK_LAST) begin
                            tick_cnt <= '0;
                            if (rx_s) begin
                                rx_valid_q <= 1'b1;
                                state      <= rx_st_idle;
                            end else begin
                                frame_err_q <= 1'b1;
                                state       <= rx_st_wait_high;
                            end
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                    rx_st_wait_high: begin
                        if (rx_s) state <= rx_st_idle;  // Line back to idle
                    end
                    default: state <= rx_st_idle;
                endcase
            end
        end
    end

    // Mid-bit sample, first bit ends up in the LSB
    always_ff @(posedge clk) begin
        if (baud_tick && state == rx_st_data && tick_cnt == TICK_LAST) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    assign link.rx_data   = shift_q;
    assign link.rx_valid  = rx_valid_q;
    assign link.frame_err = frame_err_q;

endmodule

// ==== design/uart_settings.svh ====
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Bus address of the control/status register, buffer sits one above
`define UART_BASE_ADDR 8'h00

// clk cycles per oversample tick, 104 for real baud rates
`define UART_PRESCALE 4

// Ticks per serial bit
`define UART_OVERSAMPLE 16

`endif

// ==== design/uart_top.sv ====
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  address,
    input  uart_byte_t  din,
    input  logic        w_en,
    input  logic        r_en,
    output uart_byte_t  dout,
    input  logic        rx,
    output logic        tx
);

    logic baud_tick;    // Shared by both engines

    uart_link_if link ();

    uart_baud_gen u_baud_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick),
        .rx        (rx),
        .link      (link.rx)
    );

    uart_tx u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick),
        .tx        (tx),
        .link      (link.tx)
    );

    uart_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .address   (address),
        .din       (din),
        .w_en      (w_en),
        .r_en      (r_en),
        .dout      (dout),
        .link      (link.regs)
    );

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx import uart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        baud_tick,
    output logic        tx,
    uart_link_if.tx     link
);

    localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`UART_OVERSAMPLE - 1);

    tx_state_t         state;
    logic [TICK_W-1:0] tick_cnt;
    logic [2:0]        bit_cnt;
    uart_byte_t        shift_q;
    logic              tick_last;
    logic              start_frame;

    assign tick_last = (tick_cnt == TICK_LAST);

    // Next frame starts from idle or right at the end of a stop bit
    assign start_frame = baud_tick && link.tx_load &&
                         (state == tx_st_idle || (state == tx_st_stop && tick_last));

    assign link.tx_taken = start_frame;

    always_ff @(posedge clk) begin
        if (start_frame) begin
            shift_q <= link.tx_data;
        end else if (baud_tick && tick_last && state inside {tx_st_start, tx_st_data}) begin
            shift_q <= shift_q >> 1;
        end
    end

    // ********************
    // Transmit FSM

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= tx_st_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else if (baud_tick) begin
            if (state != tx_st_idle) tick_cnt <= tick_last ? '0 : tick_cnt + 1'b1;
            if (start_frame) begin
                state <= tx_st_start;
                tx    <= 1'b0;  // Start bit
            end else if (tick_last) begin
                case (state)
                    tx_st_start: begin
                        tx      <= shift_q[0];
                        bit_cnt <= '0;
                        state   <= tx_st_data;
                    end
                    tx_st_data: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            tx    <= 1'b1;  // Stop bit
                            state <= tx_st_stop;
                        end else begin
                            tx <= shift_q[0];
                        end
                    end
                    tx_st_stop: state <= tx_st_idle;
                    default:    state <= tx_st_idle;
                endcase
            end
        end
    end

endmodule

// ==== uart_periph.f ====
+incdir+design
design/uart_pkg.sv
design/uart_link_if.sv
design/uart_baud_gen.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_regs.sv
design/uart_top.sv
verification/uart_asserts.sv
verification/uart_tb.sv

// ==== verification/uart_asserts.sv ====
`timescale 1ns/1ps

module uart_asserts import uart_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      rx_valid,
    input logic      frame_err,
    input logic      tx_taken,
    input logic      tx_load,
    input tx_state_t tx_state,
    input logic      tx
);

    // One outcome per received frame
    assert property (@(posedge clk) disable iff (!rst_n) !(rx_valid && frame_err))
        else $error("rx_valid and frame_err high in the same cycle");

    assert property (@(posedge clk) disable iff (!rst_n) tx_taken |-> tx_load)
        else $error("tx_taken pulsed while tx_load was low");

    assert property (@(posedge clk) disable iff (!rst_n) (tx_state == tx_st_idle) |-> tx)
        else $error("tx line low while the transmitter is idle");

endmodule

bind uart_top uart_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_valid  (link.rx_valid),
    .frame_err (link.frame_err),
    .tx_taken  (link.tx_taken),
    .tx_load   (link.tx_load),
    .tx_state  (u_tx.state),
    .tx        (tx)
);

// ==== verification/uart_tb.sv ====
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tb import uart_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int BIT_CLKS    = `UART_PRESCALE * `UART_OVERSAMPLE;
    localparam int N_FRAMES    = 47;    // All tests plus the idle bit after reset
    localparam int WATCHDOG_NS = N_FRAMES * 10 * BIT_CLKS * CLK_PERIOD * 2;
    localparam int MAX_POLLS   = 20 * BIT_CLKS;
    localparam logic [7:0] CTRL = `UART_BASE_ADDR;
    localparam logic [7:0] BUF  = `UART_BASE_ADDR + 8'd1;

    logic       clk;
    logic       rst_n;
    logic [7:0] address;
    uart_byte_t din;
    logic       w_en;
    logic       r_en;
    uart_byte_t dout;
    logic       rx;
    logic       tx;
    logic       rx_line;    // Line model output
    logic       loopback;

    integer     seed;
    int         err_cnt;
    int         check_cnt;
    int         test_err;
    uart_byte_t tx_sent[$];
    uart_byte_t tx_seen[$];  // Decoded from the tx pin

    assign rx = loopback ? tx : rx_line;

    uart_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .address (address),
        .din     (din),
        .w_en    (w_en),
        .r_en    (r_en),
        .dout    (dout),
        .rx      (rx),
        .tx      (tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, a test never finished", WATCHDOG_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // ********************
    // Checking helpers

    task automatic count_error();
        err_cnt++;
        test_err++;
    endtask

    task automatic check_value(input string name, input uart_byte_t exp, input uart_byte_t act);
        check_cnt++;
        assert (act === exp) else begin
            $display("ERR %s: expected %02h, actual %02h", name, exp, act);
            count_error();
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %s done with %0d error(s)", name, test_err);
        test_err = 0;
    endtask

    function automatic uart_byte_t rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Link rules checked every cycle
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!(u_dut.link.rx_valid && u_dut.link.frame_err)) else begin
                $display("rx_valid and frame_err were high in the same cycle");
                count_error();
            end
            assert (!u_dut.link.tx_taken || u_dut.link.tx_load) else begin
                $display("tx_taken pulsed while tx_load was low");
                count_error();
            end
            assert (u_dut.u_tx.state != tx_st_idle || u_dut.tx) else begin
                $display("tx line went low while the transmitter was idle");
                count_error();
            end
        end
    end

    // ********************
    // Bus tasks

    task automatic bus_write(input logic [7:0] addr, input uart_byte_t data);
        @(posedge clk);
        address <= addr;
        din     <= data;
        w_en    <= 1'b1;
        @(posedge clk);
        w_en    <= 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output uart_byte_t data);
        @(posedge clk);
        address <= addr;
        r_en    <= 1'b1;
        @(posedge clk);
        r_en    <= 1'b0;
        @(negedge clk);     // dout registered at the edge above
        data = dout;
    endtask

    task automatic read_check(input string name, input logic [7:0] addr, input uart_byte_t exp);
        uart_byte_t got;
        bus_read(addr, got);
        check_value(name, exp, got);
    endtask

    // Poll status until every bit of mask is set
    task automatic wait_status(input string name, input uart_byte_t mask);
        uart_byte_t st;
        int         polls;
        st    = '0;
        polls = 0;
        while ((st & mask) != mask && polls < MAX_POLLS) begin
            bus_read(CTRL, st);
            polls++;
        end
        assert ((st & mask) == mask) else begin
            $display("%s: status bits %02h never came up while polling", name, mask);
            count_error();
        end
    endtask

    // ********************
    // Serial line model and tx monitor

    task automatic send_frame(input uart_byte_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx_line <= frame[i];    // Start bit first, then LSB first
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
        @(posedge clk);
        rx_line <= 1'b1;
    endtask

    initial begin : tx_monitor
        uart_byte_t data;
        logic       start_ok;
        logic       stop_ok;
        forever begin
            @(negedge tx);
            repeat (BIT_CLKS / 2) @(posedge clk);   // Mid start bit
            start_ok = (tx == 1'b0);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(posedge clk);
                data[i] = tx;
            end
            repeat (BIT_CLKS) @(posedge clk);
            stop_ok = (tx == 1'b1);
            assert (start_ok && stop_ok) else begin
                $display("Frame on tx had a bad start or stop bit");
                count_error();
            end
            tx_seen.push_back(data);
        end
    end

    task automatic wait_tx_frames(input int count);
        int cycles;
        cycles = 0;
        while (tx_seen.size() < count && cycles < 3 * 10 * BIT_CLKS) begin
            @(posedge clk);
            cycles++;
        end
        assert (tx_seen.size() == count) else begin
            $display("ERR transmit_count: expected %0d, actual %0d", count, tx_seen.size());
            count_error();
        end
    endtask

    // ********************
    // Test sequence

    initial begin : main
        uart_byte_t b;
        uart_byte_t b2;
        logic       idle_ok;
        seed      = 32'h49dc7a5a;
        err_cnt   = 0;
        check_cnt = 0;
        test_err  = 0;
        rst_n    <= 1'b0;
        address  <= '0;
        din      <= '0;
        w_en     <= 1'b0;
        r_en     <= 1'b0;
        rx_line  <= 1'b1;
        loopback <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_value("reset_dout", 8'h00, dout);
        read_check("reset_status", CTRL, 8'h02);
        idle_ok = 1'b1;
        repeat (BIT_CLKS) begin
            @(negedge clk);
            idle_ok = idle_ok & tx;
        end
        check_value("reset_tx_idle", 8'h01, {7'd0, idle_ok});
        finish_test("reset");

        for (int i = 0; i < 20; i++) begin
            wait_status("transmit_empty", 8'h02);
            b = rand_byte();
            tx_sent.push_back(b);
            bus_write(BUF, b);
        end
        wait_tx_frames(20);
        for (int i = 0; i < tx_seen.size() && i < 20; i++) begin
            check_value("transmit_data", tx_sent[i], tx_seen[i]);
        end
        finish_test("transmit");

        for (int i = 0; i < 20; i++) begin
            b = rand_byte();
            send_frame(b, 1'b1);
            wait_status("receive_full", 8'h01);
            read_check("receive_data", BUF, b);
            read_check("receive_status", CTRL, 8'h02);
        end
        finish_test("receive");

        send_frame(rand_byte(), 1'b0);  // Low stop bit
        wait_status("framing_flag", 8'h04);
        read_check("framing_status", CTRL, 8'h06);
        bus_write(CTRL, 8'h04);
        read_check("framing_clear", CTRL, 8'h02);
        b = rand_byte();
        send_frame(b, 1'b1);
        wait_status("framing_recover", 8'h01);
        read_check("framing_data", BUF, b);
        finish_test("framing");

        b  = rand_byte();
        b2 = rand_byte();
        send_frame(b, 1'b1);
        send_frame(b2, 1'b1);
        wait_status("overrun_flag", 8'h08);
        read_check("overrun_status", CTRL, 8'h0b);
        read_check("overrun_data", BUF, b);
        bus_write(CTRL, 8'h08);
        read_check("overrun_clear", CTRL, 8'h02);
        finish_test("overrun");

        @(posedge clk);
        loopback <= 1'b1;
        b  = rand_byte();
        b2 = rand_byte();
        wait_status("loopback_empty", 8'h02);
        bus_write(BUF, b);
        wait_status("loopback_empty", 8'h02);   // First byte now shifting
        bus_write(BUF, b2);
        wait_status("loopback_full", 8'h01);
        read_check("loopback_data1", BUF, b);
        wait_status("loopback_full", 8'h01);
        read_check("loopback_data2", BUF, b2);
        read_check("loopback_status", CTRL, 8'h02);
        finish_test("loopback");

        $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
